/* sim.f */
rtl/ex_pkg.sv
rtl/ex_adder.sv
rtl/ex_logic_unit.sv
rtl/ex_sequencer.sv
rtl/ex_top.sv
bench/ex_checker.sv
bench/ex_monitor.sv
bench/ex_tb.sv

/* bench/ex_tb.sv */
/* Runs directed carry cases, then ALU, forwarding, back-pressure and streaming groups.
   Random fields come from a 16-bit LFSR with a fixed seed, so runs repeat exactly. */
`timescale 1ns/10ps

module ex_tb;

// Operation counts per group where forwarding counts pairs
localparam int n_directed     = 4;
localparam int n_fwd_directed = 4;
localparam int n_arith        = 40;
localparam int n_logic        = 30;
localparam int n_fwd_pairs    = 20;
localparam int n_bp           = 40;
localparam int n_stream       = 20;
localparam int n_total        = n_directed + n_fwd_directed + n_arith + n_logic
                                + 2 * n_fwd_pairs + n_bp + n_stream;
localparam int cycle_limit    = 40 * n_total + 100;

logic                              clk;
logic                              rstz;
logic [ex_pkg::xlen-1:0]           op1;
logic [ex_pkg::xlen-1:0]           op2;
logic [ex_pkg::reg_addr_width-1:0] rs1;
logic [ex_pkg::reg_addr_width-1:0] rs2;
logic                              rs1_read;
logic                              rs2_read;
logic [ex_pkg::reg_addr_width-1:0] rd;
logic                              rd_write;
logic                              illegal;
logic [ex_pkg::alu_op_width-1:0]   alu_op;
logic                              in_vld;
logic                              in_rdy;
logic [ex_pkg::xlen-1:0]           result;
logic [ex_pkg::reg_addr_width-1:0] rd_out;
logic                              rd_write_out;
logic                              illegal_out;
logic                              out_vld;
logic                              out_rdy;
logic [ex_pkg::xlen-1:0]           fwd_data;
logic                              fwd_vld;

// Stimulus state and counters
logic [15:0]                     lfsr;
logic                            bp_mode;
logic [ex_pkg::alu_op_width-1:0] code;
int                              issued;
int                              cycles;
int                              tests;
int                              errors;
int                              asserts;

ex_top UUT (.*);

ex_monitor u_monitor (.*);

bind ex_sequencer ex_checker u_checker (.*, .in_ex2(state));

// ==============================
// Clock and timeout
// ==============================

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
        $display("Timeout after %0d cycles, %0d of %0d results seen", cycles, tests, issued);
        $display("Simulation finished: FAIL");
        $finish;
    end
end

// ==============================
// Stimulus helpers
// ==============================

// Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        v    = {v[30:0], lfsr[0]};
    end
    return v;
endfunction

// One clock with random out_rdy while back-pressure is on
task automatic next_cycle();
    @(posedge clk);
    if (bp_mode) begin
        out_rdy <= (random_bits(1) != 0);
    end else begin
        out_rdy <= 1'b1;
    end
endtask

task automatic send(
    input logic [ex_pkg::alu_op_width-1:0]   op,
    input logic [ex_pkg::xlen-1:0]           a,
    input logic [ex_pkg::xlen-1:0]           b,
    input logic [ex_pkg::reg_addr_width-1:0] s1,
    input logic [ex_pkg::reg_addr_width-1:0] s2,
    input logic [1:0]                        reads,
    input logic [ex_pkg::reg_addr_width-1:0] d,
    input logic                              dw,
    input logic                              ill,
    input logic [ex_pkg::xlen-1:0]           fd,
    input logic                              fv
);
    alu_op   <= op;
    op1      <= a;
    op2      <= b;
    rs1      <= s1;
    rs2      <= s2;
    rs1_read <= reads[0];
    rs2_read <= reads[1];
    rd       <= d;
    rd_write <= dw;
    illegal  <= ill;
    fwd_data <= fd;
    fwd_vld  <= fv;
    in_vld   <= 1'b1;
    // Hold the operation until the stage takes it
    next_cycle();
    while (!in_rdy) begin
        next_cycle();
    end
    issued++;
endtask

task automatic send_plain(
    input logic [ex_pkg::alu_op_width-1:0] op,
    input logic [ex_pkg::xlen-1:0]         a,
    input logic [ex_pkg::xlen-1:0]         b
);
    send(op, a, b, '0, '0, 2'b00, '0, 1'b0, 1'b0, '0, 1'b0);
endtask

task automatic send_random(input logic [ex_pkg::alu_op_width-1:0] op);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] fd;
    logic [31:0] idx;
    logic [31:0] flags;
    a     = random_bits(32);
    b     = random_bits(32);
    fd    = random_bits(32);
    idx   = random_bits(15);
    flags = random_bits(5);
    send(op, a, b, idx[4:0], idx[9:5], flags[1:0], idx[14:10], flags[2], flags[3], fd, flags[4]);
endtask

// Producer writes d and the consumer reads d through one, both or neither source
task automatic send_dependent_pair();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] fd;
    logic [31:0] r;
    logic [ex_pkg::reg_addr_width-1:0] d;
    a = random_bits(32);
    b = random_bits(32);
    r = random_bits(14);
    d = r[4:0];
    send(ex_pkg::alu_add, a, b, '0, '0, 2'b00, d, r[5] | r[6], 1'b0, '0, 1'b0);
    a  = random_bits(32);
    b  = random_bits(32);
    fd = random_bits(32);
    send(r[7] ? ex_pkg::alu_sub : ex_pkg::alu_xor, a, b, r[8] ? d : d + 5'd1,
         r[9] ? d : d ^ 5'd3, r[11:10], d + 5'd7, 1'b1, r[12], fd, r[13]);
endtask

// ==============================
// Test sequence
// ==============================

initial begin
    lfsr     = 16'd65;
    bp_mode  = 1'b0;
    issued   = 0;
    cycles   = 0;
    rstz     = 1'b0;
    op1      = '0;
    op2      = '0;
    rs1      = '0;
    rs2      = '0;
    rs1_read = 1'b0;
    rs2_read = 1'b0;
    rd       = '0;
    rd_write = 1'b0;
    illegal  = 1'b0;
    alu_op   = ex_pkg::alu_add;
    in_vld   = 1'b0;
    out_rdy  = 1'b1;
    fwd_data = '0;
    fwd_vld  = 1'b0;
    repeat (3) @(posedge clk);
    rstz <= 1'b1;

    // Carries and borrows across bit 15 and wraparound at bit 31
    send_plain(ex_pkg::alu_add, 32'h0000_ffff, 32'h0000_0001);
    send_plain(ex_pkg::alu_add, 32'hffff_ffff, 32'h0000_0001);
    send_plain(ex_pkg::alu_sub, 32'h0000_0000, 32'h0000_0001);
    send_plain(ex_pkg::alu_sub, 32'h0001_0000, 32'h0000_0001);
    for (int i = 0; i < n_arith; i++) begin
        send_random(random_bits(1) != 0 ? ex_pkg::alu_sub : ex_pkg::alu_add);
    end

    // Walk codes 2 to 7 where the free codes must give zero
    code = ex_pkg::alu_and;
    repeat (n_logic) begin
        send_random(code);
        code = (code == 3'd7) ? ex_pkg::alu_and : code + 3'd1;
    end

    // Forwarding on rs1 only, then with fwd_vld low, then on rs2 only
    send(ex_pkg::alu_add, 32'h0000_0001, 32'h0000_0002, '0, '0, 2'b00, 5'd9, 1'b1, 1'b0,
         '0, 1'b0);
    send(ex_pkg::alu_sub, 32'h0000_0100, 32'h0000_0010, 5'd9, 5'd9, 2'b01, 5'd9, 1'b1,
         1'b0, 32'h5555_0000, 1'b1);
    send(ex_pkg::alu_xor, 32'h0f0f_0f0f, 32'h00ff_00ff, 5'd9, 5'd9, 2'b11, 5'd4, 1'b1,
         1'b0, 32'h1234_0000, 1'b0);
    send(ex_pkg::alu_or, 32'h0000_0003, 32'h0000_0030, 5'd4, 5'd4, 2'b10, 5'd12, 1'b0,
         1'b1, 32'h0a0a_0000, 1'b1);

    repeat (n_fwd_pairs) begin
        send_dependent_pair();
    end

    // Random stalls from writeback
    bp_mode = 1'b1;
    repeat (n_bp) begin
        send_random(3'(random_bits(3)));
    end
    bp_mode = 1'b0;

    // Always ready so one accept every two cycles
    repeat (n_stream) begin
        send_random(3'(random_bits(3)));
    end
    in_vld <= 1'b0;

    while (tests < issued) begin
        next_cycle();
    end
    repeat (5) next_cycle();

    asserts = UUT.u_sequencer.u_checker.failures;
    $display("Counts: %0d issued, %0d checked, %0d errors, %0d assertion failures",
             issued, tests, errors, asserts);
    if (errors == 0 && asserts == 0 && tests == issued) begin
        $display("Simulation finished: PASS");
    end else begin
        $display("Simulation finished: FAIL");
    end
    $finish;
end

endmodule

/* bench/ex_monitor.sv */
/* Expected results follow the hazard rule and plain modulo 2^32 arithmetic.
   Latency is measured from each accept to the first cycle its out_vld is seen. */
`timescale 1ns/10ps

module ex_monitor (
    input  logic                              clk,
    input  logic                              rstz,
    input  logic [ex_pkg::xlen-1:0]           op1,
    input  logic [ex_pkg::xlen-1:0]           op2,
    input  logic [ex_pkg::reg_addr_width-1:0] rs1,
    input  logic [ex_pkg::reg_addr_width-1:0] rs2,
    input  logic                              rs1_read,
    input  logic                              rs2_read,
    input  logic [ex_pkg::reg_addr_width-1:0] rd,
    input  logic                              rd_write,
    input  logic                              illegal,
    input  logic [ex_pkg::alu_op_width-1:0]   alu_op,
    input  logic                              in_vld,
    input  logic                              in_rdy,
    input  logic [ex_pkg::xlen-1:0]           fwd_data,
    input  logic                              fwd_vld,
    input  logic [ex_pkg::xlen-1:0]           result,
    input  logic [ex_pkg::reg_addr_width-1:0] rd_out,
    input  logic                              rd_write_out,
    input  logic                              illegal_out,
    input  logic                              out_vld,
    input  logic                              out_rdy,
    output int                                tests,
    output int                                errors
);

// Outstanding operations in accept order
logic [ex_pkg::xlen-1:0] exp_q[$];
logic [9:0]              ctl_q[$];   // {op, illegal, rd_write, rd}
int                      cyc_q[$];

// Model of the pending destination
logic                              pend;
logic [ex_pkg::reg_addr_width-1:0] rpend;
logic                              seen;
int                                cyc;

// ==============================
// Reference model
// ==============================

function automatic logic [ex_pkg::xlen-1:0] expected_result(
    input logic [ex_pkg::alu_op_width-1:0] op,
    input logic [ex_pkg::xlen-1:0]         a,
    input logic [ex_pkg::xlen-1:0]         b
);
    case (op)
        ex_pkg::alu_add: return a + b;
        ex_pkg::alu_sub: return a - b;
        ex_pkg::alu_and: return a & b;
        ex_pkg::alu_or:  return a | b;
        ex_pkg::alu_xor: return a ^ b;
        default:         return '0;
    endcase
endfunction

// ==============================
// Compare process
// ==============================

always @(posedge clk) begin
    logic [ex_pkg::xlen-1:0] a;
    logic [ex_pkg::xlen-1:0] b;
    logic [ex_pkg::xlen-1:0] exp_val;
    logic [9:0]              ctl;
    logic                    ok;
    if (!rstz) begin
        pend  = 1'b0;
        rpend = '0;
        seen  = 1'b0;
    end else begin
        cyc++;
        // First sight of the head result gives its latency
        if (out_vld && !seen && cyc_q.size() > 0) begin
            seen = 1'b1;
            if (cyc - cyc_q[0] != 2) begin
                errors++;
                $display("error at %0t: result valid %0d cycles after accept, expected 2",
                         $time, cyc - cyc_q[0]);
            end
        end
        // Output side first, the accept on this edge belongs to a newer op
        if (out_vld && out_rdy) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Extra result at %0t with no operation outstanding", $time);
            end else begin
                exp_val = exp_q.pop_front();
                ctl     = ctl_q.pop_front();
                void'(cyc_q.pop_front());
                ok = (result === exp_val) && ({illegal_out, rd_write_out, rd_out} === ctl[6:0]);
                tests++;
                if (!ok) begin
                    errors++;
                    $display("error at %0t: result %h ctl %h, expected %h ctl %h", $time,
                             result, {illegal_out, rd_write_out, rd_out}, exp_val, ctl[6:0]);
                end
                $display("test %0d op %0d: %s", tests, ctl[9:7], ok ? "ok" : "mismatch");
            end
            seen = 1'b0;
            // Waiting input must go in on the edge the result leaves
            if (in_vld && !in_rdy) begin
                errors++;
                $display("New operation was held off at %0t while the result was taken", $time);
            end
        end
        if (in_vld && in_rdy) begin
            a = (pend && rs1_read && rs1 == rpend && fwd_vld) ? fwd_data : op1;
            b = (pend && rs2_read && rs2 == rpend && fwd_vld) ? fwd_data : op2;
            exp_q.push_back(expected_result(alu_op, a, b));
            ctl_q.push_back({alu_op, illegal, rd_write, rd});
            cyc_q.push_back(cyc);
            pend  = rd_write;
            rpend = rd;
        end
    end
end

endmodule

/* bench/ex_checker.sv */
/* Bound into ex_sequencer and sampled on the rising clock.
   Checks are off while rstz is low, apart from the one on reset release. */
`timescale 1ns/10ps

module ex_checker (
    input logic                              clk,
    input logic                              rstz,
    input logic                              in_ex2,
    input logic                              in_vld,
    input logic                              in_rdy,
    input logic                              out_vld,
    input logic                              out_rdy,
    input logic [ex_pkg::xlen-1:0]           result,
    input logic [ex_pkg::reg_addr_width-1:0] rd_out,
    input logic                              rd_write_out,
    input logic                              illegal_out
);

int failures;

// The cycle after an accept is ex2 and takes no new work
a_no_rdy_in_ex2: assert property (@(posedge clk) disable iff (!rstz)
    in_vld && in_rdy |=> in_ex2 && !in_rdy)
    else begin
        $error("in_rdy high in ex2");
        failures++;
    end

// Nothing left over from before reset
a_idle_after_reset: assert property (@(posedge clk) $rose(rstz) |-> !out_vld)
    else begin
        $error("out_vld high right after reset");
        failures++;
    end

// Held output must not move under back-pressure
a_hold_output: assert property (@(posedge clk) disable iff (!rstz)
    out_vld && !out_rdy |=> out_vld && $stable({result, rd_out, rd_write_out, illegal_out}))
    else begin
        $error("Output changed or dropped while stalled");
        failures++;
    end

// Fixed two cycle latency
a_latency: assert property (@(posedge clk) disable iff (!rstz)
    in_vld && in_rdy |=> !out_vld ##1 out_vld)
    else begin
        $error("out_vld not raised exactly 2 cycles after accept");
        failures++;
    end

endmodule

/* rtl/ex_top.sv */
/* Latency is 2 cycles from accept to out_vld.
   A new operation is accepted only after the previous result is taken. */
`timescale 1ns/10ps

module ex_top (
    input  logic                              clk,
    input  logic                              rstz,
    // Decode side
    input  logic [ex_pkg::xlen-1:0]           op1,
    input  logic [ex_pkg::xlen-1:0]           op2,
    input  logic [ex_pkg::reg_addr_width-1:0] rs1,
    input  logic [ex_pkg::reg_addr_width-1:0] rs2,
    input  logic                              rs1_read,
    input  logic                              rs2_read,
    input  logic [ex_pkg::reg_addr_width-1:0] rd,
    input  logic                              rd_write,
    input  logic                              illegal,
    input  logic [ex_pkg::alu_op_width-1:0]   alu_op,
    input  logic                              in_vld,
    output logic                              in_rdy,
    // Writeback side
    output logic [ex_pkg::xlen-1:0]           result,
    output logic [ex_pkg::reg_addr_width-1:0] rd_out,
    output logic                              rd_write_out,
    output logic                              illegal_out,
    output logic                              out_vld,
    input  logic                              out_rdy,
    // Writeback forwarding
    input  logic [ex_pkg::xlen-1:0]           fwd_data,
    input  logic                              fwd_vld
);

// Resolved operands to both units
logic [ex_pkg::xlen-1:0] fwd_op1;
logic [ex_pkg::xlen-1:0] fwd_op2;

// Unit results back to the sequencer
logic [ex_pkg::xlen-1:0] sum;
logic [ex_pkg::xlen-1:0] logic_result;

// ==============================
// Sequencer
// ==============================

ex_sequencer u_sequencer (
    .clk          (clk),
    .rstz         (rstz),
    .op1          (op1),
    .op2          (op2),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_read     (rs1_read),
    .rs2_read     (rs2_read),
    .rd           (rd),
    .rd_write     (rd_write),
    .illegal      (illegal),
    .alu_op       (alu_op),
    .in_vld       (in_vld),
    .in_rdy       (in_rdy),
    .result       (result),
    .rd_out       (rd_out),
    .rd_write_out (rd_write_out),
    .illegal_out  (illegal_out),
    .out_vld      (out_vld),
    .out_rdy      (out_rdy),
    .fwd_data     (fwd_data),
    .fwd_vld      (fwd_vld),
    .fwd_op1      (fwd_op1),
    .fwd_op2      (fwd_op2),
    .sum          (sum),
    .logic_result (logic_result)
);

// ==============================
// Functional units
// ==============================

// Both units see the raw decode opcode in the accept cycle
ex_adder u_adder (
    .clk     (clk),
    .fwd_op1 (fwd_op1),
    .fwd_op2 (fwd_op2),
    .alu_op  (alu_op),
    .sum     (sum)
);

ex_logic_unit u_logic_unit (
    .clk          (clk),
    .fwd_op1      (fwd_op1),
    .fwd_op2      (fwd_op2),
    .alu_op       (alu_op),
    .logic_result (logic_result)
);

endmodule

/* rtl/ex_sequencer.sv */
/* Holds one operation at a time. Forwarding only covers a hazard on the
   operation accepted just before and only while fwd_vld is high. */
`timescale 1ns/10ps

module ex_sequencer (
    input  logic                              clk,
    input  logic                              rstz,
    // Decode side
    input  logic [ex_pkg::xlen-1:0]           op1,
    input  logic [ex_pkg::xlen-1:0]           op2,
    input  logic [ex_pkg::reg_addr_width-1:0] rs1,
    input  logic [ex_pkg::reg_addr_width-1:0] rs2,
    input  logic                              rs1_read,
    input  logic                              rs2_read,
    input  logic [ex_pkg::reg_addr_width-1:0] rd,
    input  logic                              rd_write,
    input  logic                              illegal,
    input  logic [ex_pkg::alu_op_width-1:0]   alu_op,
    input  logic                              in_vld,
    output logic                              in_rdy,
    // Writeback side
    output logic [ex_pkg::xlen-1:0]           result,
    output logic [ex_pkg::reg_addr_width-1:0] rd_out,
    output logic                              rd_write_out,
    output logic                              illegal_out,
    output logic                              out_vld,
    input  logic                              out_rdy,
    // Writeback forwarding
    input  logic [ex_pkg::xlen-1:0]           fwd_data,
    input  logic                              fwd_vld,
    // Functional units
    output logic [ex_pkg::xlen-1:0]           fwd_op1,
    output logic [ex_pkg::xlen-1:0]           fwd_op2,
    input  logic [ex_pkg::xlen-1:0]           sum,
    input  logic [ex_pkg::xlen-1:0]           logic_result
);

// Pending destination tracking
logic                              pending;
logic [ex_pkg::reg_addr_width-1:0] rpend;
logic                              rs1_hazard;
logic                              rs2_hazard;

// Operation code kept for the result select
logic [ex_pkg::alu_op_width-1:0] op_q;

// Input transfer strobe
logic accept;

// Sequencer state, low in ex1 and high in ex2
logic state;
logic next_state;

// ==============================
// Hazard and forwarding
// ==============================

// Source matches the destination still on its way to writeback
assign rs1_hazard = pending && rs1_read && (rs1 == rpend) && fwd_vld;
assign rs2_hazard = pending && rs2_read && (rs2 == rpend) && fwd_vld;

// Writeback value replaces the stale decoded operand
assign fwd_op1 = rs1_hazard ? fwd_data : op1;
assign fwd_op2 = rs2_hazard ? fwd_data : op2;

// ==============================
// Handshake
// ==============================

// New work only in ex1, and only once the old result is gone
assign in_rdy = !state && (!out_vld || out_rdy);
assign accept = in_vld && in_rdy;

// ==============================
// State machine
// ==============================

always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
        // Reset into ex1
        state <= 1'b0;
    end else begin
        state <= next_state;
    end
end

always_comb begin
    next_state = state;
    if (!state) begin
        // ex1 moves on once an operation is taken
        if (accept) begin
            next_state = 1'b1;
        end
    end else begin
        // ex2 lasts one cycle while the result is captured
        next_state = 1'b0;
    end
end

// ==============================
// Control and pending tracking
// ==============================

always_ff @(posedge clk or negedge rstz) begin
    if (!rstz) begin
        out_vld <= 1'b0;
        pending <= 1'b0;
        rpend   <= '0;
    end else if (!state) begin
        if (accept) begin
            // Previous result, if any, leaves on this same edge
            out_vld <= 1'b0;
            pending <= rd_write;
            rpend   <= rd;
        end else if (out_vld && out_rdy) begin
            out_vld <= 1'b0;
        end
    end else begin
        // Units have settled so the result goes out
        out_vld <= 1'b1;
    end
end

// ==============================
// Payload registers
// ==============================

// Control fields travel alongside the operation
always_ff @(posedge clk) begin
    if (accept) begin
        op_q         <= alu_op;
        rd_out       <= rd;
        rd_write_out <= rd_write;
        illegal_out  <= illegal;
    end
end

// Result select is written only in ex2 so it holds under back-pressure
always_ff @(posedge clk) begin
    if (state) begin
        case (op_q)
            ex_pkg::alu_add,
            ex_pkg::alu_sub: begin
                result <= sum;
            end
            ex_pkg::alu_and,
            ex_pkg::alu_or,
            ex_pkg::alu_xor: begin
                result <= logic_result;
            end
            default: begin
                result <= '0;
            end
        endcase
    end
end

endmodule

/* rtl/ex_logic_unit.sv */
/* Result is registered on every clock edge from the operands present.
   Any code outside AND, OR and XOR registers zero. */
`timescale 1ns/10ps

module ex_logic_unit (
    input  logic                            clk,
    input  logic [ex_pkg::xlen-1:0]         fwd_op1,
    input  logic [ex_pkg::xlen-1:0]         fwd_op2,
    input  logic [ex_pkg::alu_op_width-1:0] alu_op,
    output logic [ex_pkg::xlen-1:0]         logic_result
);

// Bitwise candidates
logic [ex_pkg::xlen-1:0] r_and;
logic [ex_pkg::xlen-1:0] r_or;
logic [ex_pkg::xlen-1:0] r_xor;

// ==============================
// Bitwise functions
// ==============================

assign r_and = fwd_op1 & fwd_op2;
assign r_or  = fwd_op1 | fwd_op2;
assign r_xor = fwd_op1 ^ fwd_op2;

// ==============================
// Result register
// ==============================

// Only the selected function is kept for the second cycle
always_ff @(posedge clk) begin
    case (alu_op)
        ex_pkg::alu_and: begin
            logic_result <= r_and;
        end
        ex_pkg::alu_or: begin
            logic_result <= r_or;
        end
        ex_pkg::alu_xor: begin
            logic_result <= r_xor;
        end
        default: begin
            // Adder codes and free codes
            logic_result <= '0;
        end
    endcase
end

endmodule

/* rtl/ex_adder.sv */
/* Operands are sampled on every clock edge and sum is valid in the cycle after.
   Subtraction is done as op1 + ~op2 + 1. */
`timescale 1ns/10ps

module ex_adder (
    input  logic                          clk,
    input  logic [ex_pkg::xlen-1:0]       fwd_op1,
    input  logic [ex_pkg::xlen-1:0]       fwd_op2,
    input  logic [ex_pkg::alu_op_width-1:0] alu_op,
    output logic [ex_pkg::xlen-1:0]       sum
);

// Split of the operands into halves
logic [ex_pkg::xlen/2-1:0] a_lo;
logic [ex_pkg::xlen/2-1:0] a_hi;
logic [ex_pkg::xlen/2-1:0] b_lo;
logic [ex_pkg::xlen/2-1:0] b_hi;

// Second operand after optional inversion
logic [ex_pkg::xlen-1:0] operand_b;
logic                    carry_in;

// First stage registers
logic [ex_pkg::xlen/2-1:0] low_sum;
logic                      low_carry;
logic [ex_pkg::xlen/2-1:0] high_sum0;
logic [ex_pkg::xlen/2-1:0] high_sum1;

// ==============================
// Operand preparation
// ==============================

// Subtract injects a carry and flips op2
assign carry_in  = (alu_op == ex_pkg::alu_sub);
assign operand_b = carry_in ? ~fwd_op2 : fwd_op2;

assign a_lo = fwd_op1[ex_pkg::xlen/2-1:0];
assign a_hi = fwd_op1[ex_pkg::xlen-1:ex_pkg::xlen/2];
assign b_lo = operand_b[ex_pkg::xlen/2-1:0];
assign b_hi = operand_b[ex_pkg::xlen-1:ex_pkg::xlen/2];

// ==============================
// Stage one
// ==============================

always_ff @(posedge clk) begin
    // Low half with its carry out
    {low_carry, low_sum} <= {1'b0, a_lo} + {1'b0, b_lo}
                            + {{(ex_pkg::xlen/2){1'b0}}, carry_in};
    // Both candidates for the high half
    // Carry out of bit 31 is dropped, result wraps modulo 2^32
    high_sum0 <= a_hi + b_hi;
    high_sum1 <= a_hi + b_hi + {{(ex_pkg::xlen/2-1){1'b0}}, 1'b1};
end

// ==============================
// Stage two
// ==============================

// Stored low carry picks the high half
assign sum = {(low_carry ? high_sum1 : high_sum0), low_sum};

endmodule

/* rtl/ex_pkg.sv */
/* Widths are fixed by the 32-bit instruction set.
   Operation codes 5 to 7 are unused and give a zero result. */
package ex_pkg;

// ==============================
// Data path widths
// ==============================

// Operand and result width
localparam int xlen = 32;

// Register index width for 32 registers
localparam int reg_addr_width = 5;

// Width of the ALU operation code
localparam int alu_op_width = 3;

// ==============================
// ALU operation codes
// ==============================

// Arithmetic group goes through the adder
localparam logic [alu_op_width-1:0] alu_add = 3'd0;
localparam logic [alu_op_width-1:0] alu_sub = 3'd1;

// Bitwise group goes through the logic unit
localparam logic [alu_op_width-1:0] alu_and = 3'd2;
localparam logic [alu_op_width-1:0] alu_or  = 3'd3;
localparam logic [alu_op_width-1:0] alu_xor = 3'd4;

// Codes 5 to 7 are left free

endpackage
